//--- rtl/soc_bus_pkg.sv
package soc_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths and memory map
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int BE_W   = DATA_W / 8;
  localparam int OFS_W  = 12;  // byte offset inside a 4 KiB window

  localparam logic [ADDR_W-1:0] RAM_BASE    = 32'h0020_0000;
  localparam logic [ADDR_W-1:0] GPIO_BASE   = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] TIMER_BASE  = 32'h8000_2000;
  localparam logic [ADDR_W-1:0] REGION_SIZE = 32'h0000_1000;

  // register offsets
  localparam logic [OFS_W-1:0] GPIO_OUT_OFS    = 12'h000;
  localparam logic [OFS_W-1:0] GPIO_IN_OFS     = 12'h004;
  localparam logic [OFS_W-1:0] TIMER_CTRL_OFS  = 12'h000;
  localparam logic [OFS_W-1:0] TIMER_COUNT_OFS = 12'h004;
  localparam logic [OFS_W-1:0] TIMER_CMP_OFS   = 12'h008;

  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_GPIO,
    DEV_TIMER,
    DEV_NONE   // unmapped, answered with an error
  } dev_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // request and response words
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              valid;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              valid;
    logic              we;
    logic [BE_W-1:0]   be;
    dev_sel_e          sel;
    logic [OFS_W-1:0]  offset;
    logic [DATA_W-1:0] wdata;
  } dev_req_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } dev_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  // byte-enable merge of a write into a register value
  function automatic logic [DATA_W-1:0] be_merge(input logic [DATA_W-1:0] old_val,
                                                 input logic [DATA_W-1:0] new_val,
                                                 input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

endpackage

//--- rtl/addr_decode_stage.sv
`timescale 1ns/1ps

module addr_decode_stage
  import soc_bus_pkg::*;
(
  input  logic     clk_sys_in,
  input  logic     rst_sys_in,
  input  bus_req_t host_req_i,
  output dev_req_t dec_req_o
);

  dev_req_t req_d;
  dev_req_t req_q;
  logic     valid_q;

  // true when addr falls inside the 4 KiB window at base
  function automatic logic in_window(input logic [ADDR_W-1:0] addr,
                                     input logic [ADDR_W-1:0] base);
    return (addr - base) < REGION_SIZE;  // unsigned, wraps below base
  endfunction

  always_comb begin
    req_d        = '0;
    req_d.valid  = host_req_i.valid;
    req_d.we     = host_req_i.we;
    req_d.be     = host_req_i.be;
    req_d.offset = host_req_i.addr[OFS_W-1:0];
    req_d.wdata  = host_req_i.wdata;
    if (in_window(host_req_i.addr, RAM_BASE)) req_d.sel = DEV_RAM;
    else if (in_window(host_req_i.addr, GPIO_BASE)) req_d.sel = DEV_GPIO;
    else if (in_window(host_req_i.addr, TIMER_BASE)) req_d.sel = DEV_TIMER;
    else req_d.sel = DEV_NONE;
  end

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= host_req_i.valid;
    end
  end

  always_ff @(posedge clk_sys_in) begin
    req_q <= req_d;  // payload, qualified by valid_q
  end

  always_comb begin
    dec_req_o       = req_q;
    dec_req_o.valid = valid_q;
  end

endmodule

//--- rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram
  import soc_bus_pkg::*;
#(
  parameter int RAM_WORDS = 1024
) (
  input  logic     clk_sys_in,
  input  logic     rst_sys_in,
  input  dev_req_t dec_req_i,
  output dev_rsp_t rsp_o
);

  localparam int AW = $clog2(RAM_WORDS);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic              valid_q;
  logic              hit;
  logic [AW-1:0]     idx;

  assign hit = dec_req_i.valid && (dec_req_i.sel == DEV_RAM);
  assign idx = dec_req_i.offset[AW+1:2];  // word index, upper offset bits alias

  always_ff @(posedge clk_sys_in) begin
    if (hit && dec_req_i.we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (dec_req_i.be[b]) mem[idx][8*b +: 8] <= dec_req_i.wdata[8*b +: 8];
      end
    end
    if (hit) begin
      rdata_q <= dec_req_i.we ? '0 : mem[idx];  // writes answer with zero
    end
  end

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= hit;
    end
  end

  assign rsp_o.valid = valid_q;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- rtl/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs
  import soc_bus_pkg::*;
#(
  parameter int GPI_W = 8,
  parameter int GPO_W = 8
) (
  input  logic             clk_sys_in,
  input  logic             rst_sys_in,
  input  dev_req_t         dec_req_i,
  input  logic [GPI_W-1:0] gp_i,
  output logic [GPO_W-1:0] gp_o,
  output dev_rsp_t         rsp_o
);

  logic [GPO_W-1:0]  gpo_q;
  logic [GPI_W-1:0]  gpi_meta;
  logic [GPI_W-1:0]  gpi_sync;
  logic [DATA_W-1:0] rdata_q;
  logic              valid_q;
  logic              hit;

  assign hit = dec_req_i.valid && (dec_req_i.sel == DEV_GPIO);

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      gpo_q    <= '0;
      gpi_meta <= '0;
      gpi_sync <= '0;
      valid_q  <= 1'b0;
    end else begin
      gpi_meta <= gp_i;      // two-flop sync
      gpi_sync <= gpi_meta;
      valid_q  <= hit;
      if (hit && dec_req_i.we && dec_req_i.offset == GPIO_OUT_OFS) begin
        gpo_q <= GPO_W'(be_merge(DATA_W'(gpo_q), dec_req_i.wdata, dec_req_i.be));
      end
    end
  end

  // read mux, registered
  always_ff @(posedge clk_sys_in) begin
    if (hit) begin
      if (dec_req_i.we) rdata_q <= '0;
      else if (dec_req_i.offset == GPIO_OUT_OFS) rdata_q <= DATA_W'(gpo_q);
      else if (dec_req_i.offset == GPIO_IN_OFS) rdata_q <= DATA_W'(gpi_sync);
      else rdata_q <= '0;
    end
  end

  assign gp_o        = gpo_q;
  assign rsp_o.valid = valid_q;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- rtl/timer_regs.sv
`timescale 1ns/1ps

module timer_regs
  import soc_bus_pkg::*;
(
  input  logic     clk_sys_in,
  input  logic     rst_sys_in,
  input  dev_req_t dec_req_i,
  output dev_rsp_t rsp_o,
  output logic     irq_o
);

  logic              en_q;     // ctrl bit 0
  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] cmp_q;
  logic              irq_q;
  logic [DATA_W-1:0] rdata_q;
  logic              valid_q;
  logic              hit;
  logic              wr;

  assign hit = dec_req_i.valid && (dec_req_i.sel == DEV_TIMER);
  assign wr  = hit && dec_req_i.we;

  ////////////////////////////////////////////////////////////////////////////
  // control, counter and compare
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      en_q    <= 1'b0;
      count_q <= '0;
      cmp_q   <= '0;
      irq_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= hit;
      if (wr && dec_req_i.offset == TIMER_CTRL_OFS && dec_req_i.be[0]) begin
        en_q <= dec_req_i.wdata[0];
      end
      if (wr && dec_req_i.offset == TIMER_COUNT_OFS) begin
        count_q <= be_merge(count_q, dec_req_i.wdata, dec_req_i.be);  // load wins
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr && dec_req_i.offset == TIMER_CMP_OFS) begin
        cmp_q <= be_merge(cmp_q, dec_req_i.wdata, dec_req_i.be);
      end
      irq_q <= en_q && (count_q >= cmp_q);  // level irq
    end
  end

  // register read back
  always_ff @(posedge clk_sys_in) begin
    if (hit) begin
      if (dec_req_i.we) rdata_q <= '0;
      else begin
        case (dec_req_i.offset)
          TIMER_CTRL_OFS:  rdata_q <= DATA_W'(en_q);
          TIMER_COUNT_OFS: rdata_q <= count_q;
          TIMER_CMP_OFS:   rdata_q <= cmp_q;
          default:         rdata_q <= '0;
        endcase
      end
    end
  end

  assign irq_o       = irq_q;
  assign rsp_o.valid = valid_q;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- rtl/resp_merge_stage.sv
`timescale 1ns/1ps

module resp_merge_stage
  import soc_bus_pkg::*;
(
  input  logic     clk_sys_in,
  input  logic     rst_sys_in,
  input  dev_req_t dec_req_i,
  input  dev_rsp_t ram_rsp_i,
  input  dev_rsp_t gpio_rsp_i,
  input  dev_rsp_t timer_rsp_i,
  output bus_rsp_t host_rsp_o
);

  logic              err_q;     // unmapped request, aligned with device responses
  logic              valid_d;
  logic [DATA_W-1:0] rdata_d;
  logic              rsp_valid_q;
  logic              rsp_err_q;
  logic [DATA_W-1:0] rsp_rdata_q;

  // at most one source is valid per cycle
  assign valid_d = ram_rsp_i.valid | gpio_rsp_i.valid | timer_rsp_i.valid | err_q;
  assign rdata_d = ({DATA_W{ram_rsp_i.valid}}   & ram_rsp_i.rdata)
                 | ({DATA_W{gpio_rsp_i.valid}}  & gpio_rsp_i.rdata)
                 | ({DATA_W{timer_rsp_i.valid}} & timer_rsp_i.rdata);

  always_ff @(posedge clk_sys_in or negedge rst_sys_in) begin
    if (!rst_sys_in) begin
      err_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      err_q       <= dec_req_i.valid && (dec_req_i.sel == DEV_NONE);
      rsp_valid_q <= valid_d;
      rsp_err_q   <= err_q;
    end
  end

  always_ff @(posedge clk_sys_in) begin
    rsp_rdata_q <= rdata_d;  // zero on error or idle
  end

  assign host_rsp_o.valid = rsp_valid_q;
  assign host_rsp_o.err   = rsp_err_q;
  assign host_rsp_o.rdata = rsp_rdata_q;

endmodule

//--- rtl/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top
  import soc_bus_pkg::*;
#(
  parameter int RAM_WORDS = 1024,
  parameter int GPI_W     = 8,
  parameter int GPO_W     = 8
) (
  input  logic             clk_sys_in,
  input  logic             rst_sys_in,
  input  bus_req_t         host_req_i,
  output bus_rsp_t         host_rsp_o,
  input  logic [GPI_W-1:0] gp_i,
  output logic [GPO_W-1:0] gp_o,
  output logic             timer_irq_o
);

  dev_req_t dec_req;
  dev_rsp_t ram_rsp;
  dev_rsp_t gpio_rsp;
  dev_rsp_t timer_rsp;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 decode, stage 2 devices, stage 3 merge
  ////////////////////////////////////////////////////////////////////////////

  addr_decode_stage u_decode (
    .clk_sys_in, .rst_sys_in,
    .host_req_i,
    .dec_req_o  (dec_req)
  );

  data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
    .clk_sys_in, .rst_sys_in,
    .dec_req_i (dec_req),
    .rsp_o     (ram_rsp)
  );

  gpio_regs #(.GPI_W(GPI_W), .GPO_W(GPO_W)) u_gpio (
    .clk_sys_in, .rst_sys_in,
    .dec_req_i (dec_req),
    .gp_i, .gp_o,            // pins
    .rsp_o     (gpio_rsp)
  );

  timer_regs u_timer (
    .clk_sys_in, .rst_sys_in,
    .dec_req_i (dec_req),
    .rsp_o     (timer_rsp),
    .irq_o     (timer_irq_o)
  );

  resp_merge_stage u_merge (
    .clk_sys_in, .rst_sys_in,
    .dec_req_i   (dec_req),
    .ram_rsp_i   (ram_rsp),
    .gpio_rsp_i  (gpio_rsp),
    .timer_rsp_i (timer_rsp),
    .host_rsp_o
  );

endmodule

//--- testbench/soc_bus_checker.sv
`timescale 1ns/1ps

module soc_bus_checker
  import soc_bus_pkg::*;
(
  input logic     clk_sys_in,
  input logic     rst_sys_in,
  input bus_req_t host_req_i,
  input bus_rsp_t host_rsp_i,
  input logic     timer_irq_i
);

  // fixed three stage latency, both directions
  a_rsp_after_req: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    host_req_i.valid |-> ##3 host_rsp_i.valid)
    else $error("no response three cycles after a request");

  a_req_before_rsp: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    host_rsp_i.valid |-> $past(host_req_i.valid, 3))
    else $error("response without a request three cycles earlier");

  a_err_no_data: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    host_rsp_i.valid && host_rsp_i.err |-> host_rsp_i.rdata == '0)
    else $error("error response carries data");

  a_known: assert property (@(posedge clk_sys_in) disable iff (!rst_sys_in)
    !$isunknown(host_rsp_i.valid) && !$isunknown(timer_irq_i))
    else $error("response valid or timer irq unknown");

endmodule

bind soc_bus_top soc_bus_checker u_checker (
  .clk_sys_in  (clk_sys_in),
  .rst_sys_in  (rst_sys_in),
  .host_req_i  (host_req_i),
  .host_rsp_i  (host_rsp_o),
  .timer_irq_i (timer_irq_o)
);

//--- testbench/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus
  import soc_bus_pkg::*;
;

  localparam int GPI_W = 8;
  localparam int GPO_W = 8;

  logic             clk_sys_in;
  logic             rst_sys_in;
  bus_req_t         host_req;
  bus_rsp_t         host_rsp;
  logic [GPI_W-1:0] gpi;
  logic [GPO_W-1:0] gpo;
  logic             timer_irq;

  logic [31:0]       lfsr;
  int                cyc;
  logic [DATA_W-1:0] ram_m [1024];   // one entry per word of the 4 KiB window
  logic [GPO_W-1:0]  gpo_m;
  logic [GPI_W-1:0]  gpi_m;
  logic [DATA_W-1:0] cmp_m;
  logic              en_m;
  logic [DATA_W-1:0] cnt_m;          // count value right after edge cnt_edge
  int                cnt_edge;
  bus_rsp_t          exp_q [$];
  int                due_q [$];
  bus_rsp_t          want_r;
  int                due_r;
  logic [DATA_W-1:0] last_rdata;
  logic [9:0]        base;
  logic [9:0]        idx_r;
  logic [3:0]        be_r;
  logic [31:0]       data_r;
  logic              we_r;

  soc_bus_top uut (
    .clk_sys_in  (clk_sys_in),
    .rst_sys_in  (rst_sys_in),
    .host_req_i  (host_req),
    .host_rsp_o  (host_rsp),
    .gp_i        (gpi),
    .gp_o        (gpo),
    .timer_irq_o (timer_irq)
  );

  initial begin
    clk_sys_in = 1'b0;
    forever #2 clk_sys_in = ~clk_sys_in;
  end

  always @(posedge clk_sys_in) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic dev_sel_e decode_addr(input logic [31:0] a);
    if (a >= RAM_BASE && a < RAM_BASE + REGION_SIZE) return DEV_RAM;
    if (a >= GPIO_BASE && a < GPIO_BASE + REGION_SIZE) return DEV_GPIO;
    if (a >= TIMER_BASE && a < TIMER_BASE + REGION_SIZE) return DEV_TIMER;
    return DEV_NONE;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] ram_addr(input logic [9:0] idx);
    return RAM_BASE + {20'h0, idx, 2'b00};
  endfunction

  task automatic abort_with_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s valid/err/rdata got %b/%b/%h expected %b/%b/%h",
               $time, name, got.valid, got.err, got.rdata, want.valid, want.err, want.rdata);
      abort_with_failure();
    end
  endtask

  task automatic check_gpo(input logic [GPO_W-1:0] got, input logic [GPO_W-1:0] want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: gp_o got %h expected %h", $time, got, want);
      abort_with_failure();
    end
  endtask

  // drive one request and queue its expected response
  task automatic send(input logic we, input logic [3:0] be, input logic [31:0] addr,
                      input logic [31:0] wdata);
    bus_rsp_t    want;
    dev_sel_e    sel;
    logic [11:0] ofs;
    logic [31:0] cnt_now;
    @(negedge clk_sys_in);
    host_req = '{valid: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    sel      = decode_addr(addr);
    ofs      = addr[11:0];
    want     = '{valid: 1'b1, err: (sel == DEV_NONE), rdata: '0};
    cnt_now  = cnt_m + (en_m ? 32'(cyc + 1 - cnt_edge) : 32'd0);  // count at the device edge
    case (sel)
      DEV_RAM: begin
        if (we) ram_m[ofs[11:2]] = merge_bytes(ram_m[ofs[11:2]], wdata, be);
        else want.rdata = ram_m[ofs[11:2]];
      end
      DEV_GPIO: begin
        if (we && ofs == GPIO_OUT_OFS) gpo_m = GPO_W'(merge_bytes(32'(gpo_m), wdata, be));
        else if (!we && ofs == GPIO_OUT_OFS) want.rdata = 32'(gpo_m);
        else if (!we && ofs == GPIO_IN_OFS) want.rdata = 32'(gpi_m);
      end
      DEV_TIMER: begin
        if (we && ofs == TIMER_COUNT_OFS) begin
          cnt_m    = merge_bytes(cnt_now, wdata, be);  // load wins over the increment
          cnt_edge = cyc + 2;
        end
        if (we && ofs == TIMER_CTRL_OFS && be[0]) begin
          cnt_m    = cnt_now + 32'(en_m);
          cnt_edge = cyc + 2;
          en_m     = wdata[0];
        end
        if (we && ofs == TIMER_CMP_OFS) cmp_m = merge_bytes(cmp_m, wdata, be);
        if (!we && ofs == TIMER_CTRL_OFS) want.rdata = 32'(en_m);
        if (!we && ofs == TIMER_COUNT_OFS) want.rdata = cnt_now;
        if (!we && ofs == TIMER_CMP_OFS) want.rdata = cmp_m;
      end
      default: ;
    endcase
    exp_q.push_back(want);
    due_q.push_back(cyc + 3);   // three edges after sampling
  endtask

  task automatic drain_responses();
    int waited;
    @(negedge clk_sys_in);
    host_req = '0;
    waited   = 0;
    while (exp_q.size() != 0) begin
      if (waited == 20) begin
        $display("timeout at %0t, responses still outstanding", $time);
        abort_with_failure();
      end
      @(negedge clk_sys_in);
      waited++;
    end
  endtask

  // irq follows the enable once the count passes compare
  task automatic wait_irq_level();
    int waited;
    waited = 0;
    while (timer_irq !== en_m) begin
      if (waited == 200) begin
        $display("timeout at %0t, timer interrupt never reached %b", $time, en_m);
        abort_with_failure();
      end
      @(negedge clk_sys_in);
      waited++;
    end
  endtask

  // response monitor, outputs are stable at the falling edge
  always @(negedge clk_sys_in) begin
    if (rst_sys_in && host_rsp.valid) begin
      if (exp_q.size() == 0) begin
        $display("response at %0t with no request outstanding", $time);
        abort_with_failure();
      end else begin
        want_r = exp_q.pop_front();
        due_r  = due_q.pop_front();
        if (cyc != due_r) begin
          $display("CHECK FAILED at %0t: host_rsp_o cycle got %0d expected %0d",
                   $time, cyc, due_r);
          abort_with_failure();
        end
        last_rdata = host_rsp.rdata;
        check_rsp("host_rsp_o", host_rsp, want_r);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_sys_in = 1'b0;
    host_req   = '0;
    gpi        = '0;
    cyc        = 0;
    lfsr       = 32'd74113;
    gpo_m      = '0;
    gpi_m      = '0;
    cmp_m      = '0;
    en_m       = 1'b0;
    cnt_m      = '0;
    cnt_edge   = 0;
    repeat (16) @(posedge clk_sys_in);
    @(negedge clk_sys_in);
    rst_sys_in = 1'b1;

    // ram: fill a block, mix partial writes and reads, read back
    base = 10'(rand_bits(10));
    for (int i = 0; i < 16; i++) begin
      data_r = rand_bits(32);
      send(1'b1, 4'hf, ram_addr(base + 10'(i)), data_r);
    end
    for (int i = 0; i < 32; i++) begin
      we_r   = 1'(rand_bits(1));
      be_r   = 4'(rand_bits(4));
      idx_r  = base + 10'(rand_bits(4));
      data_r = rand_bits(32);
      send(we_r, be_r, ram_addr(idx_r), data_r);
    end
    for (int i = 0; i < 16; i++) send(1'b0, 4'h0, ram_addr(base + 10'(i)), '0);
    drain_responses();

    // gpio out and in
    for (int i = 0; i < 4; i++) begin
      be_r   = 4'(rand_bits(4));
      data_r = rand_bits(32);
      send(1'b1, be_r, GPIO_BASE + GPIO_OUT_OFS, data_r);
      drain_responses();
      check_gpo(gpo, gpo_m);
      send(1'b0, 4'h0, GPIO_BASE + GPIO_OUT_OFS, '0);
      drain_responses();
      gpi   = GPI_W'(rand_bits(GPI_W));
      gpi_m = gpi;
      repeat (3) @(negedge clk_sys_in);   // past the synchronizer
      send(1'b0, 4'h0, GPIO_BASE + GPIO_IN_OFS, '0);
      drain_responses();
    end

    // unmapped, bit 30 set is outside every window
    data_r = rand_bits(32) | 32'h4000_0000;
    send(1'b1, 4'hf, data_r, rand_bits(32));
    send(1'b0, 4'h0, data_r, '0);
    send(1'b0, 4'h0, ram_addr(base), '0);
    drain_responses();

    // timer interrupt
    send(1'b1, 4'hf, TIMER_BASE + TIMER_COUNT_OFS, '0);
    send(1'b1, 4'hf, TIMER_BASE + TIMER_CMP_OFS, 32'd8 + rand_bits(4));
    send(1'b1, 4'h1, TIMER_BASE + TIMER_CTRL_OFS, 32'd1);
    drain_responses();
    wait_irq_level();
    send(1'b0, 4'h0, TIMER_BASE + TIMER_COUNT_OFS, '0);
    drain_responses();
    if (last_rdata < cmp_m) begin
      $display("CHECK FAILED at %0t: timer count %0d below compare %0d",
               $time, last_rdata, cmp_m);
      abort_with_failure();
    end
    send(1'b1, 4'h1, TIMER_BASE + TIMER_CTRL_OFS, '0);
    drain_responses();
    wait_irq_level();

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- src.f
rtl/soc_bus_pkg.sv
rtl/addr_decode_stage.sv
rtl/data_ram.sv
rtl/gpio_regs.sv
rtl/timer_regs.sv
rtl/resp_merge_stage.sv
rtl/soc_bus_top.sv
testbench/soc_bus_checker.sv
testbench/tb_soc_bus.sv
